// File: source/dtif_lsu_pkg.sv
// lsu side of the debug-trigger interface: widths and check FSM state codes
package dtif_lsu_pkg;

  // request payload widths
  localparam int pa_width    = 40;
  localparam int data_width  = 64;
  localparam int bytes_width = 16;
  localparam int size_width  = 3;

  // ==============================
  // check FSM encoding
  // ==============================
  localparam int state_width = 3;

  localparam logic [state_width-1:0] st_idle       = 3'd0;
  localparam logic [state_width-1:0] st_addr_chk   = 3'd1;
  localparam logic [state_width-1:0] st_data_chk   = 3'd2;
  localparam logic [state_width-1:0] st_wait_data  = 3'd3;
  localparam logic [state_width-1:0] st_wait_pipe  = 3'd4;
  localparam logic [state_width-1:0] st_wait_cmplt = 3'd5;

endpackage

// File: source/dtif_dtu_pkg.sv
// trigger unit side of the debug-trigger interface: halt info and ldst type codes
package dtif_dtu_pkg;

  // halt info word from the trigger unit
  localparam int hinfo_width      = 22;
  localparam int hinfo_cancel_bit = 0;

  // ldst type, bit 1 marks load and bit 0 marks store
  localparam int ldst_type_width = 2;

  localparam logic [ldst_type_width-1:0] ldst_load  = 2'b10;
  localparam logic [ldst_type_width-1:0] ldst_store = 2'b01;
  // atomics match on both the load and the store side
  localparam logic [ldst_type_width-1:0] ldst_both  = 2'b11;

endpackage

// File: source/dtif_check_fsm.sv
// check FSM: sequences address and data checks and drives stage control
`timescale 1ns/1ps

module dtif_check_fsm (
  input  logic                                dt_fsm_clk,
  input  logic                                cpurst_b,
  input  logic                                flush,
  input  logic                                req,
  input  logic                                addr_ready,
  input  logic                                st_type,
  input  logic                                split_last,
  input  logic                                data_chk_mask,
  input  logic                                pipe_down,
  input  logic                                addr_trig_en,
  input  logic                                data_trig_en,
  input  logic                                halt_info_vld,
  input  logic [dtif_dtu_pkg::hinfo_width-1:0] halt_info,
  input  logic                                any_data_vld,
  output logic                                fsm_idle,
  output logic                                fsm_addr_chk,
  output logic                                fsm_data_chk,
  output logic                                addr_chk_en,
  output logic                                data_chk_en,
  output logic                                addr_up,
  output logic                                data_up,
  output logic                                stall,
  output logic                                cmplt_ready,
  output logic                                pipedown_mask,
  output logic                                halt_info_up,
  output logic                                trig_en
);

  logic [dtif_lsu_pkg::state_width-1:0] cur_state;
  logic [dtif_lsu_pkg::state_width-1:0] next_state;
  logic addr_start;
  logic data_start;
  logic cancel;
  logic fsm_wait_data;
  logic fsm_wait_cmplt;

  // ==============================
  // enables and start conditions
  // ==============================
  assign addr_chk_en = addr_trig_en;
  assign data_chk_en = data_trig_en && !data_chk_mask;

  assign addr_start = req && addr_ready && addr_chk_en;
  // data-only check, address side is off
  assign data_start = req && data_chk_en && !addr_chk_en;

  assign cancel = halt_info_vld && halt_info[dtif_dtu_pkg::hinfo_cancel_bit];

  // ==============================
  // state register
  // ==============================
  always_ff @(posedge dt_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= dtif_lsu_pkg::st_idle;
    else if (flush)
      cur_state <= dtif_lsu_pkg::st_idle;
    else
      cur_state <= next_state;
  end

  always_comb
  begin
    next_state = cur_state;
    case (cur_state)
      dtif_lsu_pkg::st_idle:
        if (addr_start)
          next_state = dtif_lsu_pkg::st_addr_chk;
        else if (data_start)
          // stores have data later, loads only after pipe down
          next_state = st_type ? dtif_lsu_pkg::st_wait_data : dtif_lsu_pkg::st_wait_pipe;
      dtif_lsu_pkg::st_addr_chk:
        if (halt_info_vld && split_last && !data_chk_en || cancel)
          next_state = dtif_lsu_pkg::st_wait_cmplt;
        else if (halt_info_vld && data_chk_en && st_type)
          next_state = dtif_lsu_pkg::st_wait_data;
        else if (halt_info_vld)
          next_state = dtif_lsu_pkg::st_wait_pipe;
      dtif_lsu_pkg::st_data_chk:
        if (halt_info_vld && split_last || cancel)
          next_state = dtif_lsu_pkg::st_wait_cmplt;
        else if (halt_info_vld)
          next_state = dtif_lsu_pkg::st_wait_pipe;
      dtif_lsu_pkg::st_wait_data:
        if (any_data_vld)
          next_state = dtif_lsu_pkg::st_data_chk;
      dtif_lsu_pkg::st_wait_pipe:
        if (pipe_down && !st_type && data_chk_en)
          next_state = dtif_lsu_pkg::st_wait_data;
        else if (pipe_down)
          next_state = dtif_lsu_pkg::st_idle;
      dtif_lsu_pkg::st_wait_cmplt:
        if (pipe_down)
          next_state = dtif_lsu_pkg::st_idle;
      default:
        next_state = dtif_lsu_pkg::st_idle;
    endcase
  end

  // ==============================
  // decoded outputs
  // ==============================
  assign fsm_idle       = (cur_state == dtif_lsu_pkg::st_idle);
  assign fsm_addr_chk   = (cur_state == dtif_lsu_pkg::st_addr_chk);
  assign fsm_data_chk   = (cur_state == dtif_lsu_pkg::st_data_chk);
  assign fsm_wait_data  = (cur_state == dtif_lsu_pkg::st_wait_data);
  assign fsm_wait_cmplt = (cur_state == dtif_lsu_pkg::st_wait_cmplt);

  // capture strobes
  assign addr_up = fsm_idle && addr_start;
  assign data_up = fsm_wait_data && any_data_vld;

  // hold the ag stage while a check is pending
  assign stall = fsm_idle && req && (addr_chk_en || data_chk_en)
                 || fsm_addr_chk || fsm_data_chk || fsm_wait_data;

  assign cmplt_ready = fsm_wait_cmplt;
  // load data is checked after pipe down, so mask it until then
  assign pipedown_mask = fsm_wait_cmplt && data_chk_en && !st_type;
  assign halt_info_up  = (fsm_addr_chk || fsm_data_chk) && halt_info_vld;
  assign trig_en       = addr_chk_en || data_chk_en;

endmodule

// File: source/dtif_addr_capture.sv
// address capture: holds the checked address, byte enables and last flag
`timescale 1ns/1ps

module dtif_addr_capture (
  input  logic                                  dt_fsm_clk,
  input  logic                                  addr_up,
  input  logic [dtif_lsu_pkg::pa_width-1:0]     addr,
  input  logic [dtif_lsu_pkg::bytes_width-1:0]  bytes_vld,
  input  logic                                  split_last,
  input  logic                                  data_chk_en,
  output logic [dtif_lsu_pkg::pa_width-1:0]     addr_q,
  output logic [dtif_lsu_pkg::bytes_width-1:0]  bytes_vld_q,
  output logic                                  addr_chk_last_q
);

  logic addr_chk_last;

  // addr check closes the match only when no data check follows
  assign addr_chk_last = split_last && !data_chk_en;

  always_ff @(posedge dt_fsm_clk)
  begin
    if (addr_up)
    begin
      addr_q          <= addr;
      bytes_vld_q     <= bytes_vld;
      addr_chk_last_q <= addr_chk_last;
    end
  end

endmodule

// File: source/dtif_data_capture.sv
// data capture: picks check data from three sources and holds it with its flags
`timescale 1ns/1ps

module dtif_data_capture (
  input  logic                                 dt_fsm_clk,
  input  logic                                 data_up,
  input  logic                                 ag_data_vld,
  input  logic [dtif_lsu_pkg::data_width-1:0]  ag_data,
  input  logic                                 da_data_vld,
  input  logic [dtif_lsu_pkg::data_width-1:0]  da_data,
  input  logic                                 vlsu_data_vld,
  input  logic [dtif_lsu_pkg::data_width-1:0]  vlsu_data,
  input  logic                                 addr_chk_en,
  input  logic                                 st_type,
  input  logic                                 split_last,
  output logic                                 any_data_vld,
  output logic [dtif_lsu_pkg::data_width-1:0]  data_q,
  output logic                                 rdata_vld_q,
  output logic                                 data_chk_last_q
);

  logic [dtif_lsu_pkg::data_width-1:0] sel_data;
  logic data_chk_last;

  assign any_data_vld = ag_data_vld || da_data_vld || vlsu_data_vld;

  // da load data first, then ag store data, vector last
  assign sel_data = da_data_vld ? da_data :
                    ag_data_vld ? ag_data :
                    vlsu_data;

  // loads check data once, stores on the last split
  assign data_chk_last = !addr_chk_en || !st_type || split_last;

  always_ff @(posedge dt_fsm_clk)
  begin
    if (data_up)
    begin
      data_q          <= sel_data;
      rdata_vld_q     <= da_data_vld;
      data_chk_last_q <= data_chk_last;
    end
  end

endmodule

// File: source/dtif_check_request.sv
// check request: one-pulse address and data requests to the trigger unit
`timescale 1ns/1ps

module dtif_check_request (
  input  logic                                    dt_fsm_clk,
  input  logic                                    cpurst_b,
  input  logic                                    flush,
  input  logic                                    fsm_addr_chk,
  input  logic                                    fsm_data_chk,
  input  logic                                    halt_info_vld,
  input  logic                                    amo_type,
  input  logic                                    st_type,
  input  logic                                    rdata_vld_q,
  input  logic                                    addr_chk_last_q,
  input  logic                                    data_chk_last_q,
  output logic                                    ldst_addr_vld,
  output logic                                    ldst_data_vld,
  output logic [dtif_dtu_pkg::ldst_type_width-1:0] ldst_type,
  output logic                                    last_check
);

  logic fsm_chk;
  logic wait_flag;
  logic [dtif_dtu_pkg::ldst_type_width-1:0] addr_type;
  logic [dtif_dtu_pkg::ldst_type_width-1:0] data_type;

  assign fsm_chk = fsm_addr_chk || fsm_data_chk;

  // ==============================
  // wait flag
  // ==============================
  // set while a request is out and the response is still pending
  always_ff @(posedge dt_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wait_flag <= 1'b0;
    else if (flush || fsm_chk && halt_info_vld)
      wait_flag <= 1'b0;
    else if (fsm_chk)
      wait_flag <= 1'b1;
  end

  assign ldst_addr_vld = fsm_addr_chk && !wait_flag;
  assign ldst_data_vld = fsm_data_chk && !wait_flag;

  // ==============================
  // request type and last flag
  // ==============================
  assign addr_type = amo_type ? dtif_dtu_pkg::ldst_both :
                     st_type  ? dtif_dtu_pkg::ldst_store :
                     dtif_dtu_pkg::ldst_load;
  // data side is split, rdata means load data
  assign data_type = rdata_vld_q ? dtif_dtu_pkg::ldst_load : dtif_dtu_pkg::ldst_store;

  assign ldst_type  = ldst_addr_vld ? addr_type : data_type;
  assign last_check = ldst_addr_vld && addr_chk_last_q
                      || ldst_data_vld && data_chk_last_q;

endmodule

// File: source/lsu_dtif_top.sv
// lsu debug-trigger interface top: check FSM, captures and request issue
`timescale 1ns/1ps

module lsu_dtif_top (
  input  logic                                  dt_fsm_clk,
  input  logic                                  cpurst_b,
  // address generation stage
  input  logic                                  ag_dtu_req,
  input  logic                                  ag_dtu_addr_ready,
  input  logic [dtif_lsu_pkg::pa_width-1:0]     ag_dtu_addr,
  input  logic [dtif_lsu_pkg::bytes_width-1:0]  ag_dtu_bytes_vld,
  input  logic                                  ag_dtu_st_type,
  input  logic                                  ag_dtu_amo_type,
  input  logic                                  ag_dtu_split_last,
  input  logic                                  ag_dtu_data_chk_mask,
  input  logic [dtif_lsu_pkg::size_width-1:0]   ag_dtu_mem_access_size,
  input  logic [dtif_dtu_pkg::hinfo_width-1:0]  ag_dtu_halt_info,
  input  logic                                  ag_dtu_pipe_down,
  input  logic                                  ag_dtu_data_vld,
  input  logic [dtif_lsu_pkg::data_width-1:0]   ag_dtu_data,
  // data access stage and vector unit
  input  logic                                  da_dtu_data_vld,
  input  logic [dtif_lsu_pkg::data_width-1:0]   da_dtu_data,
  input  logic                                  vlsu_dtu_data_vld,
  input  logic [dtif_lsu_pkg::data_width-1:0]   vlsu_dtu_data,
  // trigger unit and retire
  input  logic                                  dtu_lsu_addr_trig_en,
  input  logic                                  dtu_lsu_data_trig_en,
  input  logic                                  dtu_lsu_halt_info_vld,
  input  logic [dtif_dtu_pkg::hinfo_width-1:0]  dtu_lsu_halt_info,
  input  logic                                  rtu_yy_xx_flush,
  // back to the ag stage
  output logic                                  dtif_ag_stall,
  output logic                                  dtif_ag_cmplt_ready,
  output logic                                  dtif_ag_fsm_idle,
  output logic                                  dtif_ag_pipedown_mask,
  output logic                                  dtif_ag_halt_info_up,
  output logic [dtif_dtu_pkg::hinfo_width-1:0]  dtif_ag_halt_info,
  output logic                                  dtif_ag_trig_en,
  // to the trigger unit
  output logic                                  lsu_dtu_ldst_addr_vld,
  output logic [dtif_lsu_pkg::pa_width-1:0]     lsu_dtu_ldst_addr,
  output logic [dtif_lsu_pkg::bytes_width-1:0]  lsu_dtu_ldst_bytes_vld,
  output logic                                  lsu_dtu_ldst_data_vld,
  output logic [dtif_lsu_pkg::data_width-1:0]   lsu_dtu_ldst_data,
  output logic [dtif_dtu_pkg::ldst_type_width-1:0] lsu_dtu_ldst_type,
  output logic                                  lsu_dtu_last_check,
  output logic [dtif_lsu_pkg::size_width-1:0]   lsu_dtu_mem_access_size,
  output logic [dtif_dtu_pkg::hinfo_width-1:0]  lsu_dtu_halt_info
);

  logic fsm_addr_chk;
  logic fsm_data_chk;
  logic addr_chk_en;
  logic data_chk_en;
  logic addr_up;
  logic data_up;
  logic any_data_vld;
  logic rdata_vld_q;
  logic addr_chk_last_q;
  logic data_chk_last_q;

  // ==============================
  // check FSM
  // ==============================
  dtif_check_fsm i_check_fsm (
    .dt_fsm_clk    (dt_fsm_clk),
    .cpurst_b      (cpurst_b),
    .flush         (rtu_yy_xx_flush),
    .req           (ag_dtu_req),
    .addr_ready    (ag_dtu_addr_ready),
    .st_type       (ag_dtu_st_type),
    .split_last    (ag_dtu_split_last),
    .data_chk_mask (ag_dtu_data_chk_mask),
    .pipe_down     (ag_dtu_pipe_down),
    .addr_trig_en  (dtu_lsu_addr_trig_en),
    .data_trig_en  (dtu_lsu_data_trig_en),
    .halt_info_vld (dtu_lsu_halt_info_vld),
    .halt_info     (dtu_lsu_halt_info),
    .any_data_vld  (any_data_vld),
    .fsm_idle      (dtif_ag_fsm_idle),
    .fsm_addr_chk  (fsm_addr_chk),
    .fsm_data_chk  (fsm_data_chk),
    .addr_chk_en   (addr_chk_en),
    .data_chk_en   (data_chk_en),
    .addr_up       (addr_up),
    .data_up       (data_up),
    .stall         (dtif_ag_stall),
    .cmplt_ready   (dtif_ag_cmplt_ready),
    .pipedown_mask (dtif_ag_pipedown_mask),
    .halt_info_up  (dtif_ag_halt_info_up),
    .trig_en       (dtif_ag_trig_en)
  );

  // ==============================
  // captures
  // ==============================
  dtif_addr_capture i_addr_capture (
    .dt_fsm_clk      (dt_fsm_clk),
    .addr_up         (addr_up),
    .addr            (ag_dtu_addr),
    .bytes_vld       (ag_dtu_bytes_vld),
    .split_last      (ag_dtu_split_last),
    .data_chk_en     (data_chk_en),
    .addr_q          (lsu_dtu_ldst_addr),
    .bytes_vld_q     (lsu_dtu_ldst_bytes_vld),
    .addr_chk_last_q (addr_chk_last_q)
  );

  dtif_data_capture i_data_capture (
    .dt_fsm_clk      (dt_fsm_clk),
    .data_up         (data_up),
    .ag_data_vld     (ag_dtu_data_vld),
    .ag_data         (ag_dtu_data),
    .da_data_vld     (da_dtu_data_vld),
    .da_data         (da_dtu_data),
    .vlsu_data_vld   (vlsu_dtu_data_vld),
    .vlsu_data       (vlsu_dtu_data),
    .addr_chk_en     (addr_chk_en),
    .st_type         (ag_dtu_st_type),
    .split_last      (ag_dtu_split_last),
    .any_data_vld    (any_data_vld),
    .data_q          (lsu_dtu_ldst_data),
    .rdata_vld_q     (rdata_vld_q),
    .data_chk_last_q (data_chk_last_q)
  );

  // ==============================
  // request issue
  // ==============================
  dtif_check_request i_check_request (
    .dt_fsm_clk      (dt_fsm_clk),
    .cpurst_b        (cpurst_b),
    .flush           (rtu_yy_xx_flush),
    .fsm_addr_chk    (fsm_addr_chk),
    .fsm_data_chk    (fsm_data_chk),
    .halt_info_vld   (dtu_lsu_halt_info_vld),
    .amo_type        (ag_dtu_amo_type),
    .st_type         (ag_dtu_st_type),
    .rdata_vld_q     (rdata_vld_q),
    .addr_chk_last_q (addr_chk_last_q),
    .data_chk_last_q (data_chk_last_q),
    .ldst_addr_vld   (lsu_dtu_ldst_addr_vld),
    .ldst_data_vld   (lsu_dtu_ldst_data_vld),
    .ldst_type       (lsu_dtu_ldst_type),
    .last_check      (lsu_dtu_last_check)
  );

  // halt info and size go straight across
  assign dtif_ag_halt_info       = dtu_lsu_halt_info;
  assign lsu_dtu_halt_info       = ag_dtu_halt_info;
  assign lsu_dtu_mem_access_size = ag_dtu_mem_access_size;

endmodule

// File: bench/tb_lsu_dtif.sv
// testbench for the lsu debug-trigger interface, driven from a stimulus file
`timescale 1ns/1ps

module tb_lsu_dtif;

  localparam int max_tests = 32;

  logic dt_fsm_clk;
  logic cpurst_b;
  logic ag_dtu_req;
  logic ag_dtu_addr_ready;
  logic [dtif_lsu_pkg::pa_width-1:0] ag_dtu_addr;
  logic [dtif_lsu_pkg::bytes_width-1:0] ag_dtu_bytes_vld;
  logic ag_dtu_st_type;
  logic ag_dtu_amo_type;
  logic ag_dtu_split_last;
  logic ag_dtu_data_chk_mask;
  logic [dtif_lsu_pkg::size_width-1:0] ag_dtu_mem_access_size;
  logic [dtif_dtu_pkg::hinfo_width-1:0] ag_dtu_halt_info;
  logic ag_dtu_pipe_down;
  logic ag_dtu_data_vld;
  logic [dtif_lsu_pkg::data_width-1:0] ag_dtu_data;
  logic da_dtu_data_vld;
  logic [dtif_lsu_pkg::data_width-1:0] da_dtu_data;
  logic vlsu_dtu_data_vld;
  logic [dtif_lsu_pkg::data_width-1:0] vlsu_dtu_data;
  logic dtu_lsu_addr_trig_en;
  logic dtu_lsu_data_trig_en;
  logic dtu_lsu_halt_info_vld;
  logic [dtif_dtu_pkg::hinfo_width-1:0] dtu_lsu_halt_info;
  logic rtu_yy_xx_flush;
  logic dtif_ag_stall;
  logic dtif_ag_cmplt_ready;
  logic dtif_ag_fsm_idle;
  logic dtif_ag_pipedown_mask;
  logic dtif_ag_halt_info_up;
  logic [dtif_dtu_pkg::hinfo_width-1:0] dtif_ag_halt_info;
  logic dtif_ag_trig_en;
  logic lsu_dtu_ldst_addr_vld;
  logic [dtif_lsu_pkg::pa_width-1:0] lsu_dtu_ldst_addr;
  logic [dtif_lsu_pkg::bytes_width-1:0] lsu_dtu_ldst_bytes_vld;
  logic lsu_dtu_ldst_data_vld;
  logic [dtif_lsu_pkg::data_width-1:0] lsu_dtu_ldst_data;
  logic [dtif_dtu_pkg::ldst_type_width-1:0] lsu_dtu_ldst_type;
  logic lsu_dtu_last_check;
  logic [dtif_lsu_pkg::size_width-1:0] lsu_dtu_mem_access_size;
  logic [dtif_dtu_pkg::hinfo_width-1:0] lsu_dtu_halt_info;

  // test table, one entry per stimulus line
  reg [8*16-1:0] t_name [0:max_tests-1];
  int t_kind [0:max_tests-1];
  int t_st [0:max_tests-1];
  int t_amo [0:max_tests-1];
  int t_split [0:max_tests-1];
  reg [39:0] t_addr [0:max_tests-1];
  reg [15:0] t_bytes [0:max_tests-1];
  reg [63:0] t_data [0:max_tests-1];
  int t_src [0:max_tests-1];
  int t_delay [0:max_tests-1];
  int t_cancel [0:max_tests-1];
  int t_exp_type [0:max_tests-1];
  int t_exp_last [0:max_tests-1];
  reg [63:0] t_exp_val [0:max_tests-1];
  int t_exp_cmplt [0:max_tests-1];
  int t_exp_mask [0:max_tests-1];

  int ntests;
  int errs;
  int passed;
  int failed;
  int cycles;
  int cycle_limit;
  integer seed;
  reg [8*16-1:0] cur_name;

  lsu_dtif_top i_dut (.*);

  always #50 dt_fsm_clk = ~dt_fsm_clk;

  // run limit, set from the test count once the file is read
  always @(posedge dt_fsm_clk)
  begin
    cycles = cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("run stopped: cycle limit of %0d reached before the tests ended", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_val(input reg [8*16-1:0] what, input reg [63:0] exp,
                           input reg [63:0] act);
    if (exp !== act)
    begin
      $display("Mismatch test=%0s signal=%0s expected=%h actual=%h", cur_name, what, exp, act);
      errs = errs + 1;
    end
  endtask

  // no check request may be on the bus in this cycle
  task automatic check_no_pulse();
    check_val("addr_vld", 0, lsu_dtu_ldst_addr_vld);
    check_val("data_vld", 0, lsu_dtu_ldst_data_vld);
  endtask

  task automatic drive_sources(input int i);
    ag_dtu_data_vld   = t_src[i][0];
    da_dtu_data_vld   = t_src[i][1];
    vlsu_dtu_data_vld = t_src[i][2];
    ag_dtu_data   = t_data[i];
    da_dtu_data   = t_data[i] + 64'd1;
    vlsu_dtu_data = t_data[i] + 64'd2;
  endtask

  task automatic read_tests();
    integer fd;
    integer r;
    string line;
    fd = $fopen("bench/lsu_dtif_stimulus.txt", "r");
    if (fd == 0)
      $display("could not open the stimulus file");
    else
    begin
      while (!$feof(fd) && ntests < max_tests)
      begin
        r = $fgets(line, fd);
        if (r > 1 && line.getc(0) != "#")
        begin
          r = $sscanf(line, "%s %d %d %d %d %h %h %h %d %d %d %d %d %h %d %d",
                      t_name[ntests], t_kind[ntests], t_st[ntests], t_amo[ntests],
                      t_split[ntests], t_addr[ntests], t_bytes[ntests], t_data[ntests],
                      t_src[ntests], t_delay[ntests], t_cancel[ntests],
                      t_exp_type[ntests], t_exp_last[ntests], t_exp_val[ntests],
                      t_exp_cmplt[ntests], t_exp_mask[ntests]);
          if (r == 16)
            ntests = ntests + 1;
        end
      end
      $fclose(fd);
    end
  endtask

  // ==============================
  // one test from the table
  // ==============================
  task automatic run_test(input int i);
    int errs_before;
    int k;
    logic [31:0] rnd;
    errs_before = errs;
    cur_name = t_name[i];
    @(negedge dt_fsm_clk);
    dtu_lsu_addr_trig_en = (t_kind[i] == 1 || t_kind[i] == 3);
    dtu_lsu_data_trig_en = (t_kind[i] == 2);
    ag_dtu_st_type    = t_st[i];
    ag_dtu_amo_type   = t_amo[i];
    ag_dtu_split_last = t_split[i];
    ag_dtu_addr       = t_addr[i];
    ag_dtu_bytes_vld  = t_bytes[i];
    // pass-through fields change from test to test
    rnd = $random(seed);
    ag_dtu_halt_info = rnd[dtif_dtu_pkg::hinfo_width-1:0];
    rnd = $random(seed);
    ag_dtu_mem_access_size = rnd[dtif_lsu_pkg::size_width-1:0];
    ag_dtu_req        = 1'b1;
    ag_dtu_addr_ready = 1'b1;
    #1;
    check_val("stall", t_kind[i] != 0, dtif_ag_stall);
    check_val("trig_en", t_kind[i] != 0, dtif_ag_trig_en);
    check_val("halt_info", ag_dtu_halt_info, lsu_dtu_halt_info);
    check_val("access_size", ag_dtu_mem_access_size, lsu_dtu_mem_access_size);
    @(negedge dt_fsm_clk);
    if (t_kind[i] == 0)
    begin
      check_no_pulse();
      check_val("fsm_idle", 1, dtif_ag_fsm_idle);
      ag_dtu_req = 1'b0;
    end
    else
    begin
      if (t_kind[i] == 2)
      begin
        ag_dtu_req = 1'b0;
        check_val("stall", t_st[i], dtif_ag_stall);
        // a load waits for pipe down before its data shows up
        if (t_st[i] == 0)
        begin
          ag_dtu_pipe_down = 1'b1;
          @(negedge dt_fsm_clk);
          ag_dtu_pipe_down = 1'b0;
        end
        drive_sources(i);
        @(negedge dt_fsm_clk);
        check_val("data_vld", 1, lsu_dtu_ldst_data_vld);
        check_val("data", t_exp_val[i], lsu_dtu_ldst_data);
        ag_dtu_data_vld   = 1'b0;
        da_dtu_data_vld   = 1'b0;
        vlsu_dtu_data_vld = 1'b0;
      end
      else
      begin
        check_val("addr_vld", 1, lsu_dtu_ldst_addr_vld);
        check_val("addr", t_exp_val[i], lsu_dtu_ldst_addr);
        check_val("bytes_vld", t_bytes[i], lsu_dtu_ldst_bytes_vld);
        ag_dtu_req = 1'b0;
      end
      check_val("ldst_type", t_exp_type[i], lsu_dtu_ldst_type);
      check_val("last_check", t_exp_last[i], lsu_dtu_last_check);
      if (t_kind[i] == 3)
      begin
        @(negedge dt_fsm_clk);
        check_no_pulse();
        rtu_yy_xx_flush = 1'b1;
        @(negedge dt_fsm_clk);
        rtu_yy_xx_flush = 1'b0;
        check_val("fsm_idle", 1, dtif_ag_fsm_idle);
        check_val("stall", 0, dtif_ag_stall);
        @(negedge dt_fsm_clk);
        check_no_pulse();
      end
      else
      begin
        for (k = 0; k < t_delay[i]; k++)
        begin
          @(negedge dt_fsm_clk);
          check_no_pulse();
          check_val("stall", 1, dtif_ag_stall);
        end
        rnd = $random(seed);
        dtu_lsu_halt_info_vld = 1'b1;
        dtu_lsu_halt_info = {rnd[dtif_dtu_pkg::hinfo_width-2:0], t_cancel[i][0]};
        #1;
        check_val("halt_info_up", 1, dtif_ag_halt_info_up);
        check_val("ag_halt_info", dtu_lsu_halt_info, dtif_ag_halt_info);
        @(negedge dt_fsm_clk);
        dtu_lsu_halt_info_vld = 1'b0;
        check_no_pulse();
        check_val("stall", 0, dtif_ag_stall);
        check_val("cmplt_ready", t_exp_cmplt[i], dtif_ag_cmplt_ready);
        check_val("pipedown_mask", t_exp_mask[i], dtif_ag_pipedown_mask);
        ag_dtu_pipe_down = 1'b1;
        @(negedge dt_fsm_clk);
        ag_dtu_pipe_down = 1'b0;
        check_val("fsm_idle", 1, dtif_ag_fsm_idle);
      end
    end
    dtu_lsu_addr_trig_en = 1'b0;
    dtu_lsu_data_trig_en = 1'b0;
    if (errs == errs_before)
    begin
      passed = passed + 1;
      $display("test %0s: pass", cur_name);
    end
    else
    begin
      failed = failed + 1;
      $display("test %0s: fail", cur_name);
    end
  endtask

  initial
  begin
    seed = 32'h80d5_4a9b;
    dt_fsm_clk = 1'b0;
    cpurst_b = 1'b0;
    ag_dtu_req = 1'b0;
    ag_dtu_addr_ready = 1'b0;
    ag_dtu_addr = '0;
    ag_dtu_bytes_vld = '0;
    ag_dtu_st_type = 1'b0;
    ag_dtu_amo_type = 1'b0;
    ag_dtu_split_last = 1'b0;
    ag_dtu_data_chk_mask = 1'b0;
    ag_dtu_mem_access_size = 3'd3;
    ag_dtu_halt_info = '0;
    ag_dtu_pipe_down = 1'b0;
    ag_dtu_data_vld = 1'b0;
    ag_dtu_data = '0;
    da_dtu_data_vld = 1'b0;
    da_dtu_data = '0;
    vlsu_dtu_data_vld = 1'b0;
    vlsu_dtu_data = '0;
    dtu_lsu_addr_trig_en = 1'b0;
    dtu_lsu_data_trig_en = 1'b0;
    dtu_lsu_halt_info_vld = 1'b0;
    dtu_lsu_halt_info = '0;
    rtu_yy_xx_flush = 1'b0;
    ntests = 0;
    errs = 0;
    passed = 0;
    failed = 0;
    cycles = 0;
    cycle_limit = 1000;
    read_tests();
    cycle_limit = ntests * 40 + 20;
    repeat (10) @(posedge dt_fsm_clk);
    @(negedge dt_fsm_clk);
    cpurst_b = 1'b1;
    @(negedge dt_fsm_clk);
    // idle state straight out of reset
    cur_name = "reset";
    check_val("fsm_idle", 1, dtif_ag_fsm_idle);
    check_val("stall", 0, dtif_ag_stall);
    check_val("cmplt_ready", 0, dtif_ag_cmplt_ready);
    check_val("pipedown_mask", 0, dtif_ag_pipedown_mask);
    check_val("halt_info_up", 0, dtif_ag_halt_info_up);
    check_val("trig_en", 0, dtif_ag_trig_en);
    check_val("last_check", 0, lsu_dtu_last_check);
    check_no_pulse();
    $display("test reset: %0s", errs == 0 ? "pass" : "fail");
    if (errs != 0)
      failed = failed + 1;
    else
      passed = passed + 1;
    for (int i = 0; i < ntests; i++)
      run_test(i);
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             passed + failed, passed, failed, errs);
    if (errs == 0 && ntests > 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: bench/lsu_dtif_stimulus.txt
# name kind(0 none,1 addr,2 data,3 flush) st amo split addr bytes data src(ag,da,vlsu bits)
# delay cancel exp_type exp_last exp_val exp_cmplt exp_mask
no_trig 0 0 0 1 0000001000 00ff 0000000000000000 0 0 0 0 0 0 0 0
no_trig_st 0 1 0 0 0000002000 ff00 0000000000000000 0 0 0 0 0 0 0 0
addr_load 1 0 0 1 12345678a0 00ff 0000000000000000 0 0 0 2 1 12345678a0 1 0
addr_store 1 1 0 1 00abcdef40 ff00 0000000000000000 0 2 0 1 1 00abcdef40 1 0
addr_amo 1 1 1 1 8000000010 000f 0000000000000000 0 3 0 3 1 8000000010 1 0
addr_split 1 1 0 0 7f00001000 f0f0 0000000000000000 0 1 0 1 0 7f00001000 0 0
addr_cancel 1 0 0 0 0123456780 0f0f 0000000000000000 0 4 1 2 0 0123456780 1 0
addr_long 1 0 0 1 ffffffff00 ffff 0000000000000000 0 7 0 2 1 ffffffff00 1 0
addr_amo_mid 1 0 1 0 0000000040 0003 0000000000000000 0 1 0 3 0 0000000040 0 0
data_st_ag 2 1 0 1 0000000000 0000 1122334455667780 1 1 0 1 1 1122334455667780 1 0
data_st_vlsu 2 1 0 0 0000000000 0000 a0a0a0a0b0b0b0c0 4 0 0 1 1 a0a0a0a0b0b0b0c2 0 0
data_st_agvlsu 2 1 0 1 0000000000 0000 0f0f0f0f0f0f0f00 5 2 1 1 1 0f0f0f0f0f0f0f00 1 0
data_st_da 2 1 0 0 0000000000 0000 0000000100000000 3 0 1 2 1 0000000100000001 1 0
data_ld_da 2 0 0 1 0000000000 0000 5555aaaa5555aa00 2 1 0 2 1 5555aaaa5555aa01 1 1
data_ld_all 2 0 0 0 0000000000 0000 123456789abcdef0 7 3 1 2 1 123456789abcdef1 1 1
data_ld_vlsu 2 0 0 1 0000000000 0000 00000000ffff0000 4 2 0 1 1 00000000ffff0002 1 1
flush_addr 3 1 0 1 4444444400 00f0 0000000000000000 0 2 0 1 1 4444444400 0 0
flush_amo 3 0 1 0 0000000020 0001 0000000000000000 0 2 0 3 0 0000000020 0 0

// File: flist.f
source/dtif_lsu_pkg.sv
source/dtif_dtu_pkg.sv
source/dtif_check_fsm.sv
source/dtif_addr_capture.sv
source/dtif_data_capture.sv
source/dtif_check_request.sv
source/lsu_dtif_top.sv
bench/tb_lsu_dtif.sv
